//--- logic/coh_bus_pkg.sv
// ----------------------------
// shared types for the coherence bus
// request message encoding
// data word and requester id
// ----------------------------

package coh_bus_pkg;

	// ----------------------------
	// data path widths
	// ----------------------------

	// one block is a single data word
	localparam int WORD_W = 64;

	// ----------------------------
	// request messages
	// ----------------------------

	// MSG_NONE   idle, nothing to do
	// MSG_GET_S  read a block, takes a response slot
	// MSG_PUT_M  write a block back, no response
	typedef enum logic [1:0] {
		MSG_NONE  = 2'd0,
		MSG_GET_S = 2'd1,
		MSG_PUT_M = 2'd2
	} msg_e;

	// ----------------------------
	// payload and requester types
	// ----------------------------

	// block data word
	typedef logic [WORD_W-1:0] word_t;

	// requester number, core 0 or core 1
	typedef logic core_id_t;

endpackage : coh_bus_pkg

//--- logic/bus_arbiter.sv
// ----------------------------
// two-core request arbiter
// alternating priority, blocked cores skipped
// request mux and acknowledge generation
// ----------------------------

`timescale 1ns/10ps

module bus_arbiter #(
	parameter int TAG_W = 4,
	parameter int IDX_W = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	// core 0 request
	input  logic                 core0_req_en_i,
	input  logic [TAG_W-1:0]     core0_req_tag_i,
	input  logic [IDX_W-1:0]     core0_req_idx_i,
	input  coh_bus_pkg::word_t   core0_req_data_i,
	input  coh_bus_pkg::msg_e    core0_req_msg_i,
	// core 1 request
	input  logic                 core1_req_en_i,
	input  logic [TAG_W-1:0]     core1_req_tag_i,
	input  logic [IDX_W-1:0]     core1_req_idx_i,
	input  coh_bus_pkg::word_t   core1_req_data_i,
	input  coh_bus_pkg::msg_e    core1_req_msg_i,
	// queue status
	input  logic                 pend_hit0_i,
	input  logic                 pend_hit1_i,
	input  logic                 q_full_i,
	// acknowledges
	output logic                 core0_req_ack_o,
	output logic                 core1_req_ack_o,
	// accepted request
	output logic                 req_acc_o,
	output coh_bus_pkg::core_id_t req_id_o,
	output coh_bus_pkg::msg_e    req_msg_o,
	output logic [TAG_W-1:0]     req_tag_o,
	output logic [IDX_W-1:0]     req_idx_o,
	output coh_bus_pkg::word_t   req_data_o
);
	import coh_bus_pkg::*;

	// 0 means core 0 preferred
	logic prio_r;
	logic ok0;
	logic ok1;
	logic gnt0;
	logic gnt1;

	// a core may go when enabled, not blocked by a pending read,
	// and not a read facing a full queue
	assign ok0 = core0_req_en_i && !pend_hit0_i &&
		!(core0_req_msg_i == MSG_GET_S && q_full_i);
	assign ok1 = core1_req_en_i && !pend_hit1_i &&
		!(core1_req_msg_i == MSG_GET_S && q_full_i);

	// preferred core first, other core as fallback
	assign gnt0 = ok0 && (!prio_r || !ok1);
	assign gnt1 = ok1 && (prio_r || !ok0);

	assign core0_req_ack_o = gnt0;
	assign core1_req_ack_o = gnt1;
	assign req_acc_o       = gnt0 || gnt1;

	// ----------------------------
	// request mux
	// ----------------------------
	assign req_id_o   = gnt1;
	assign req_msg_o  = gnt1 ? core1_req_msg_i  : core0_req_msg_i;
	assign req_tag_o  = gnt1 ? core1_req_tag_i  : core0_req_tag_i;
	assign req_idx_o  = gnt1 ? core1_req_idx_i  : core0_req_idx_i;
	assign req_data_o = gnt1 ? core1_req_data_i : core0_req_data_i;

	// priority flips every cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			prio_r <= 1'b0;
		end else begin
			prio_r <= ~prio_r;
		end
	end

endmodule : bus_arbiter

//--- logic/rsp_queue.sv
// ----------------------------
// in-order response queue
// slot allocation on accepted reads
// out-of-order fill by slot pointer
// in-order drain, pending-block lookup
// ----------------------------

`timescale 1ns/10ps

module rsp_queue #(
	parameter int TAG_W   = 4,
	parameter int IDX_W   = 4,
	parameter int Q_DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	// current core addresses for the lookup
	input  logic [TAG_W-1:0]             core0_req_tag_i,
	input  logic [IDX_W-1:0]             core0_req_idx_i,
	input  logic [TAG_W-1:0]             core1_req_tag_i,
	input  logic [IDX_W-1:0]             core1_req_idx_i,
	// accepted request
	input  logic                         req_acc_i,
	input  coh_bus_pkg::core_id_t        req_id_i,
	input  coh_bus_pkg::msg_e            req_msg_i,
	input  logic [TAG_W-1:0]             req_tag_i,
	input  logic [IDX_W-1:0]             req_idx_i,
	// fill from memory
	input  logic                         fill_vld_i,
	input  logic [$clog2(Q_DEPTH)-1:0]   fill_ptr_i,
	input  coh_bus_pkg::word_t           fill_data_i,
	// response acknowledges
	input  logic                         core0_rsp_ack_i,
	input  logic                         core1_rsp_ack_i,
	// status
	output logic                         pend_hit0_o,
	output logic                         pend_hit1_o,
	output logic                         q_full_o,
	output logic [$clog2(Q_DEPTH)-1:0]   alloc_ptr_o,
	// head slot
	output logic                         rsp_vld_o,
	output coh_bus_pkg::core_id_t        rsp_id_o,
	output logic [TAG_W-1:0]             rsp_tag_o,
	output logic [IDX_W-1:0]             rsp_idx_o,
	output coh_bus_pkg::word_t           rsp_data_o
);
	import coh_bus_pkg::*;

	localparam int PTR_W = $clog2(Q_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;
	// slot index plus wrap bit
	typedef logic [PTR_W:0]   wptr_t;

	// ----------------------------
	// slot storage
	// ----------------------------
	logic [TAG_W-1:0] tag_q  [Q_DEPTH];
	logic [IDX_W-1:0] idx_q  [Q_DEPTH];
	core_id_t         id_q   [Q_DEPTH];
	word_t            data_q [Q_DEPTH];
	logic [Q_DEPTH-1:0] vld_q;
	logic [Q_DEPTH-1:0] rdy_q;

	wptr_t head_r;
	wptr_t tail_r;
	ptr_t  head_idx;
	ptr_t  tail_idx;
	logic  alloc;
	logic  ack_named;
	logic  pop;

	assign head_idx = head_r[PTR_W-1:0];
	assign tail_idx = tail_r[PTR_W-1:0];

	// same slot, opposite wrap bits
	assign q_full_o    = (head_r[PTR_W] != tail_r[PTR_W]) && (head_idx == tail_idx);
	assign alloc_ptr_o = tail_idx;
	assign alloc       = req_acc_i && (req_msg_i == MSG_GET_S);

	// head slot drives the response
	assign rsp_vld_o  = vld_q[head_idx] && rdy_q[head_idx];
	assign rsp_id_o   = id_q[head_idx];
	assign rsp_tag_o  = tag_q[head_idx];
	assign rsp_idx_o  = idx_q[head_idx];
	assign rsp_data_o = data_q[head_idx];

	// the other core's ack has no effect
	assign ack_named = rsp_id_o ? core1_rsp_ack_i : core0_rsp_ack_i;
	assign pop       = rsp_vld_o && ack_named;

	// look for an outstanding read of either core's block
	always_comb begin
		pend_hit0_o = 1'b0;
		pend_hit1_o = 1'b0;
		for (int i = 0; i < Q_DEPTH; i++) begin
			if (vld_q[i] && tag_q[i] == core0_req_tag_i && idx_q[i] == core0_req_idx_i) begin
				pend_hit0_o = 1'b1;
			end
			if (vld_q[i] && tag_q[i] == core1_req_tag_i && idx_q[i] == core1_req_idx_i) begin
				pend_hit1_o = 1'b1;
			end
		end
	end

	// ----------------------------
	// control state
	// ----------------------------
	// alloc, fill and pop never touch the same slot in one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			vld_q  <= '0;
			rdy_q  <= '0;
		end else begin
			if (alloc) begin
				vld_q[tail_idx] <= 1'b1;
				rdy_q[tail_idx] <= 1'b0;
				tail_r          <= tail_r + 1'b1;
			end
			if (fill_vld_i) begin
				rdy_q[fill_ptr_i] <= 1'b1;
			end
			if (pop) begin
				vld_q[head_idx] <= 1'b0;
				rdy_q[head_idx] <= 1'b0;
				head_r          <= head_r + 1'b1;
			end
		end
	end

	// slot payload
	always_ff @(posedge clk) begin
		if (alloc) begin
			tag_q[tail_idx] <= req_tag_i;
			idx_q[tail_idx] <= req_idx_i;
			id_q[tail_idx]  <= req_id_i;
		end
		if (fill_vld_i) begin
			data_q[fill_ptr_i] <= fill_data_i;
		end
	end

	// arbiter must hold reads back while full
	a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
		alloc |-> !q_full_o);

	// memory returns each read once, to a live slot
	a_fill_slot: assert property (@(posedge clk) disable iff (rst)
		fill_vld_i |-> vld_q[fill_ptr_i] && !rdy_q[fill_ptr_i]);

	// a core acks only a ready head slot addressed to it
	a_ack0_named: assert property (@(posedge clk) disable iff (rst)
		core0_rsp_ack_i |-> rsp_vld_o && rsp_id_o == 1'b0);
	a_ack1_named: assert property (@(posedge clk) disable iff (rst)
		core1_rsp_ack_i |-> rsp_vld_o && rsp_id_o == 1'b1);

endmodule : rsp_queue

//--- logic/mem_ctrl.sv
// ----------------------------
// block memory controller
// single-cycle writeback
// fixed-latency read pipeline
// ----------------------------

`timescale 1ns/10ps

module mem_ctrl #(
	parameter int TAG_W   = 4,
	parameter int IDX_W   = 4,
	parameter int Q_DEPTH = 4,
	parameter int MEM_LAT = 3
) (
	input  logic                         clk,
	input  logic                         rst,
	// accepted request
	input  logic                         req_acc_i,
	input  coh_bus_pkg::msg_e            req_msg_i,
	input  logic [TAG_W-1:0]             req_tag_i,
	input  logic [IDX_W-1:0]             req_idx_i,
	input  coh_bus_pkg::word_t           req_data_i,
	input  logic [$clog2(Q_DEPTH)-1:0]   alloc_ptr_i,
	// fill to the response queue
	output logic                         fill_vld_o,
	output logic [$clog2(Q_DEPTH)-1:0]   fill_ptr_o,
	output coh_bus_pkg::word_t           fill_data_o
);
	import coh_bus_pkg::*;

	localparam int PTR_W   = $clog2(Q_DEPTH);
	localparam int ADDR_W  = TAG_W + IDX_W;
	localparam int N_WORDS = 1 << ADDR_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [PTR_W-1:0]  ptr_t;

	word_t mem_q [N_WORDS];
	addr_t addr;
	logic  rd_go;
	logic  wr_go;

	// read pipeline, stage 0 loaded at acceptance
	logic [MEM_LAT-1:0] pipe_vld;
	ptr_t               pipe_ptr  [MEM_LAT];
	word_t              pipe_data [MEM_LAT];

	// block address is tag then index
	assign addr  = {req_tag_i, req_idx_i};
	assign rd_go = req_acc_i && (req_msg_i == MSG_GET_S);
	assign wr_go = req_acc_i && (req_msg_i == MSG_PUT_M);

	// ----------------------------
	// memory array
	// ----------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N_WORDS; i++) begin
				mem_q[i] <= '0;
			end
		end else if (wr_go) begin
			mem_q[addr] <= req_data_i;
		end
	end

	// ----------------------------
	// read pipeline
	// ----------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_vld <= '0;
		end else begin
			pipe_vld[0] <= rd_go;
			for (int k = 1; k < MEM_LAT; k++) begin
				pipe_vld[k] <= pipe_vld[k-1];
			end
		end
	end

	// word as it stands before this edge's writeback
	always_ff @(posedge clk) begin
		pipe_ptr[0]  <= alloc_ptr_i;
		pipe_data[0] <= mem_q[addr];
		for (int k = 1; k < MEM_LAT; k++) begin
			pipe_ptr[k]  <= pipe_ptr[k-1];
			pipe_data[k] <= pipe_data[k-1];
		end
	end

	// last stage is the fill
	assign fill_vld_o  = pipe_vld[MEM_LAT-1];
	assign fill_ptr_o  = pipe_ptr[MEM_LAT-1];
	assign fill_data_o = pipe_data[MEM_LAT-1];

endmodule : mem_ctrl

//--- logic/coh_bus_top.sv
// ----------------------------
// coherence bus top level
// arbiter, response queue and memory controller
// ----------------------------

`timescale 1ns/10ps

module coh_bus_top #(
	parameter int TAG_W   = 4,
	parameter int IDX_W   = 4,
	parameter int Q_DEPTH = 4,
	parameter int MEM_LAT = 3
) (
	input  logic                  clk,
	input  logic                  rst,
	// core 0
	input  logic                  core0_req_en_i,
	input  logic [TAG_W-1:0]      core0_req_tag_i,
	input  logic [IDX_W-1:0]      core0_req_idx_i,
	input  coh_bus_pkg::word_t    core0_req_data_i,
	input  coh_bus_pkg::msg_e     core0_req_msg_i,
	output logic                  core0_req_ack_o,
	input  logic                  core0_rsp_ack_i,
	// core 1
	input  logic                  core1_req_en_i,
	input  logic [TAG_W-1:0]      core1_req_tag_i,
	input  logic [IDX_W-1:0]      core1_req_idx_i,
	input  coh_bus_pkg::word_t    core1_req_data_i,
	input  coh_bus_pkg::msg_e     core1_req_msg_i,
	output logic                  core1_req_ack_o,
	input  logic                  core1_rsp_ack_i,
	// response
	output logic                  rsp_vld_o,
	output coh_bus_pkg::core_id_t rsp_id_o,
	output logic [TAG_W-1:0]      rsp_tag_o,
	output logic [IDX_W-1:0]      rsp_idx_o,
	output coh_bus_pkg::word_t    rsp_data_o
);
	import coh_bus_pkg::*;

	localparam int PTR_W = $clog2(Q_DEPTH);

	// arbiter to queue and memory
	logic             req_acc;
	core_id_t         req_id;
	msg_e             req_msg;
	logic [TAG_W-1:0] req_tag;
	logic [IDX_W-1:0] req_idx;
	word_t            req_data;
	// queue status
	logic             pend_hit0;
	logic             pend_hit1;
	logic             q_full;
	logic [PTR_W-1:0] alloc_ptr;
	// memory fill
	logic             fill_vld;
	logic [PTR_W-1:0] fill_ptr;
	word_t            fill_data;

	bus_arbiter #(.TAG_W(TAG_W), .IDX_W(IDX_W)) arb0 (
		.clk(clk), .rst(rst),
		.core0_req_en_i(core0_req_en_i), .core0_req_tag_i(core0_req_tag_i),
		.core0_req_idx_i(core0_req_idx_i), .core0_req_data_i(core0_req_data_i),
		.core0_req_msg_i(core0_req_msg_i),
		.core1_req_en_i(core1_req_en_i), .core1_req_tag_i(core1_req_tag_i),
		.core1_req_idx_i(core1_req_idx_i), .core1_req_data_i(core1_req_data_i),
		.core1_req_msg_i(core1_req_msg_i),
		.pend_hit0_i(pend_hit0), .pend_hit1_i(pend_hit1), .q_full_i(q_full),
		.core0_req_ack_o(core0_req_ack_o), .core1_req_ack_o(core1_req_ack_o),
		.req_acc_o(req_acc), .req_id_o(req_id), .req_msg_o(req_msg),
		.req_tag_o(req_tag), .req_idx_o(req_idx), .req_data_o(req_data)
	);

	rsp_queue #(.TAG_W(TAG_W), .IDX_W(IDX_W), .Q_DEPTH(Q_DEPTH)) rq0 (
		.clk(clk), .rst(rst),
		.core0_req_tag_i(core0_req_tag_i), .core0_req_idx_i(core0_req_idx_i),
		.core1_req_tag_i(core1_req_tag_i), .core1_req_idx_i(core1_req_idx_i),
		.req_acc_i(req_acc), .req_id_i(req_id), .req_msg_i(req_msg),
		.req_tag_i(req_tag), .req_idx_i(req_idx),
		.fill_vld_i(fill_vld), .fill_ptr_i(fill_ptr), .fill_data_i(fill_data),
		.core0_rsp_ack_i(core0_rsp_ack_i), .core1_rsp_ack_i(core1_rsp_ack_i),
		.pend_hit0_o(pend_hit0), .pend_hit1_o(pend_hit1), .q_full_o(q_full),
		.alloc_ptr_o(alloc_ptr),
		.rsp_vld_o(rsp_vld_o), .rsp_id_o(rsp_id_o), .rsp_tag_o(rsp_tag_o),
		.rsp_idx_o(rsp_idx_o), .rsp_data_o(rsp_data_o)
	);

	mem_ctrl #(.TAG_W(TAG_W), .IDX_W(IDX_W), .Q_DEPTH(Q_DEPTH), .MEM_LAT(MEM_LAT)) mc0 (
		.clk(clk), .rst(rst),
		.req_acc_i(req_acc), .req_msg_i(req_msg), .req_tag_i(req_tag),
		.req_idx_i(req_idx), .req_data_i(req_data), .alloc_ptr_i(alloc_ptr),
		.fill_vld_o(fill_vld), .fill_ptr_o(fill_ptr), .fill_data_o(fill_data)
	);

endmodule : coh_bus_top

//--- verif/tb_clkgen.sv
// ----------------------------
// testbench clock and reset
// 40 ns clock, reset for a few cycles
// ----------------------------

`timescale 1ns/10ps

module tb_clkgen #(
	parameter int PERIOD  = 40,
	parameter int RST_CYC = 3
) (
	output logic clk_o,
	output logic rst_o
);
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// reset seen high at the first RST_CYC rising edges
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYC) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule : tb_clkgen

//--- verif/coh_bus_tb.sv
// ----------------------------
// coherence bus testbench
// random two-core traffic with a shadow memory model
// response order, data and protocol checks
// queue-full hold phase, watchdog
// ----------------------------

`timescale 1ns/10ps

module coh_bus_tb;
	import coh_bus_pkg::*;

	localparam int TAG_W     = 4;
	localparam int IDX_W     = 4;
	localparam int Q_DEPTH   = 4;
	localparam int MEM_LAT   = 3;
	localparam int N_BLK     = 1 << (TAG_W + IDX_W);
	localparam int N_RAND    = 150;
	localparam int N_HOLD    = 24;
	localparam int HOLD_CYC  = 16;
	localparam int MODE_RAND = 0;
	localparam int MODE_HOLD = 1;
	localparam int N_REQ     = 2 * (2 * N_RAND + N_HOLD);
	localparam longint WD_NS = longint'(N_REQ) * (MEM_LAT + Q_DEPTH + 8) * 40;

	typedef logic [TAG_W+IDX_W-1:0] addr_t;

	logic clk;
	logic rst;

	// core side of the bus, index is the core number
	logic [1:0]       req_en = '0;
	logic [TAG_W-1:0] req_tag [2] = '{default: '0};
	logic [IDX_W-1:0] req_idx [2] = '{default: '0};
	word_t            req_data [2] = '{default: '0};
	msg_e             req_msg [2] = '{default: MSG_NONE};
	logic [1:0]       req_ack;
	logic [1:0]       rsp_ack = '0;

	logic             rsp_vld;
	core_id_t         rsp_id;
	logic [TAG_W-1:0] rsp_tag;
	logic [IDX_W-1:0] rsp_idx;
	word_t            rsp_data;

	// ----------------------------
	// reference model state
	// ----------------------------
	word_t    shadow [N_BLK];
	int       blk_pend [N_BLK];
	int       pend_total;
	core_id_t exp_id [$];
	addr_t    exp_addr [$];
	word_t    exp_data [$];

	// phase control, stimulus state, counters
	int         mode = MODE_RAND;
	logic       withhold = 1'b0;
	int         gen_limit = 0;
	int         issued [2];
	int         dly [2];
	int         wait_cnt [2];
	logic [7:0] hold_n = '0;
	int         put_full_cnt;
	int         n_rsp;
	int         err_val;
	int         err_proto;
	int         err_flow = 0;
	int         seed = 32'he1ec5bca;

	tb_clkgen #(.PERIOD(40), .RST_CYC(3)) clk0 (.clk_o(clk), .rst_o(rst));

	coh_bus_top dut0 (
		.clk(clk), .rst(rst),
		.core0_req_en_i(req_en[0]), .core0_req_tag_i(req_tag[0]),
		.core0_req_idx_i(req_idx[0]), .core0_req_data_i(req_data[0]),
		.core0_req_msg_i(req_msg[0]), .core0_req_ack_o(req_ack[0]),
		.core0_rsp_ack_i(rsp_ack[0]),
		.core1_req_en_i(req_en[1]), .core1_req_tag_i(req_tag[1]),
		.core1_req_idx_i(req_idx[1]), .core1_req_data_i(req_data[1]),
		.core1_req_msg_i(req_msg[1]), .core1_req_ack_o(req_ack[1]),
		.core1_rsp_ack_i(rsp_ack[1]),
		.rsp_vld_o(rsp_vld), .rsp_id_o(rsp_id), .rsp_tag_o(rsp_tag),
		.rsp_idx_o(rsp_idx), .rsp_data_o(rsp_data)
	);

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			err_val++;
		end
	endtask

	task automatic check_id(input string name, input core_id_t got, input core_id_t exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			err_val++;
		end
	endtask

	task automatic check_addr(input string name, input logic [TAG_W-1:0] got_tag,
		input logic [IDX_W-1:0] got_idx, input logic [TAG_W-1:0] exp_tag,
		input logic [IDX_W-1:0] exp_idx);
		if (got_tag !== exp_tag || got_idx !== exp_idx) begin
			$display("FAILED %s got %h/%h expected %h/%h", name, got_tag, got_idx,
				exp_tag, exp_idx);
			err_val++;
		end
	endtask

	task automatic report_error(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		err_proto++;
	endtask

	task automatic print_counts();
		$display("responses checked %0d, value errors %0d, protocol errors %0d, flow errors %0d",
			n_rsp, err_val, err_proto, err_flow);
	endtask

	// new request for core c, held until acknowledged
	task automatic issue_req(input int c);
		logic [31:0]      r;
		logic [31:0]      d_hi;
		logic [31:0]      d_lo;
		msg_e             m;
		logic [TAG_W-1:0] t;
		logic [IDX_W-1:0] x;
		r = $random(seed);
		d_hi = $random(seed);
		d_lo = $random(seed);
		if (mode == MODE_HOLD) begin
			// core 0 reads distinct blocks, core 1 writes a disjoint range
			m = (c == 0) ? MSG_GET_S : MSG_PUT_M;
			t = (c == 0) ? {2'b01, hold_n[1:0]} : {1'b1, r[6:4]};
			x = (c == 0) ? hold_n[5:2] : r[13:10];
			if (c == 0) begin
				hold_n = hold_n + 8'd1;
			end
		end else begin
			// about 70% reads, 16 blocks so addresses collide
			m = (r[3:0] < 4'd11) ? MSG_GET_S : MSG_PUT_M;
			t = {2'b00, r[5:4]};
			x = {2'b00, r[7:6]};
		end
		req_en[c]   <= 1'b1;
		req_msg[c]  <= m;
		req_tag[c]  <= t;
		req_idx[c]  <= x;
		req_data[c] <= {d_hi, d_lo};
		issued[c] = issued[c] + 1;
	endtask

	task automatic wait_idle();
		while (issued[0] < gen_limit || issued[1] < gen_limit || req_en != 2'b00 ||
			exp_id.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// ----------------------------
	// cores and reference model
	// ----------------------------
	always @(posedge clk) begin : bus_model
		logic        popped;
		core_id_t    p_id;
		addr_t       p_addr;
		addr_t       a;
		logic [31:0] rv;
		if (rst) begin
			req_en  <= '0;
			rsp_ack <= '0;
			for (int i = 0; i < N_BLK; i++) begin
				shadow[i]   = '0;
				blk_pend[i] = 0;
			end
			for (int c = 0; c < 2; c++) begin
				issued[c]   = 0;
				dly[c]      = 0;
				wait_cnt[c] = 0;
			end
			exp_id.delete();
			exp_addr.delete();
			exp_data.delete();
			pend_total   = 0;
			put_full_cnt = 0;
			n_rsp        = 0;
			err_val      = 0;
			err_proto    = 0;
		end else begin
			if (req_ack[0] && req_ack[1]) begin
				report_error("both request acknowledges high in one cycle");
			end
			for (int c = 0; c < 2; c++) begin
				a = {req_tag[c], req_idx[c]};
				if (req_ack[c] && !req_en[c]) begin
					report_error($sformatf("core %0d acknowledged with its enable low", c));
				end
				if (rsp_ack[c] && !(rsp_vld && rsp_id == c[0])) begin
					report_error($sformatf("response to core %0d withdrawn before its ack", c));
				end
				// nothing in the bus should hold this core back
				if (req_en[c] && !req_ack[c] && blk_pend[a] == 0 &&
					(req_msg[c] == MSG_PUT_M || pend_total < Q_DEPTH)) begin
					wait_cnt[c]++;
					if (wait_cnt[c] >= 2) begin
						report_error($sformatf("core %0d not served for 2 free cycles", c));
					end
				end else begin
					wait_cnt[c] = 0;
				end
			end

			// head slot popped by the named core
			popped = rsp_vld && rsp_ack[rsp_id];
			if (popped && exp_id.size() == 0) begin
				report_error("response delivered with no read outstanding");
				popped = 1'b0;
			end else if (popped) begin
				p_id = exp_id.pop_front();
				p_addr = exp_addr.pop_front();
				check_id("rsp_id_o", rsp_id, p_id);
				check_addr("rsp_tag_o/rsp_idx_o", rsp_tag, rsp_idx,
					p_addr[TAG_W+IDX_W-1:IDX_W], p_addr[IDX_W-1:0]);
				check_word("rsp_data_o", rsp_data, exp_data.pop_front());
				n_rsp++;
			end

			// accepted requests, seen against the state before this edge
			for (int c = 0; c < 2; c++) begin
				if (req_en[c] && req_ack[c]) begin
					a = {req_tag[c], req_idx[c]};
					if (req_msg[c] == MSG_GET_S) begin
						if (blk_pend[a] != 0) begin
							report_error($sformatf("read of pending block %h accepted", a));
						end
						if (pend_total >= Q_DEPTH) begin
							report_error("read accepted with every slot taken");
						end
						exp_id.push_back(c[0]);
						exp_addr.push_back(a);
						exp_data.push_back(shadow[a]);
						blk_pend[a]++;
						pend_total++;
					end else begin
						if (pend_total == Q_DEPTH) begin
							put_full_cnt++;
						end
						shadow[a] = req_data[c];
					end
				end
			end
			if (popped) begin
				blk_pend[p_addr]--;
				pend_total--;
			end

			// response acknowledges after a random delay
			for (int c = 0; c < 2; c++) begin
				if (rsp_ack[c]) begin
					rsp_ack[c] <= 1'b0;
					rv = $random(seed);
					dly[c] = int'(rv[1:0]);
				end else if (!withhold && rsp_vld && rsp_id == c[0]) begin
					if (dly[c] == 0) begin
						rsp_ack[c] <= 1'b1;
					end else begin
						dly[c]--;
					end
				end
			end

			// next request, with an occasional idle gap
			for (int c = 0; c < 2; c++) begin
				if (!req_en[c] || req_ack[c]) begin
					rv = $random(seed);
					if (issued[c] < gen_limit && rv[1:0] != 2'b00) begin
						issue_req(c);
					end else begin
						req_en[c] <= 1'b0;
					end
				end
			end
		end
	end

	// ----------------------------
	// test phases
	// ----------------------------
	initial begin : run_phases
		@(negedge clk);
		while (rst) begin
			@(negedge clk);
		end
		mode = MODE_RAND;
		gen_limit = N_RAND;
		wait_idle();

		// responses held back so the queue fills
		withhold = 1'b1;
		mode = MODE_HOLD;
		gen_limit = N_RAND + N_HOLD;
		while (pend_total != Q_DEPTH) begin
			@(negedge clk);
		end
		repeat (HOLD_CYC) @(negedge clk);
		if (put_full_cnt == 0) begin
			$display("ERROR: no writeback was accepted while the queue was full");
			err_flow++;
		end
		withhold = 1'b0;
		wait_idle();

		mode = MODE_RAND;
		gen_limit = 2 * N_RAND + N_HOLD;
		wait_idle();
		repeat (4) @(negedge clk);
		if (rsp_vld) begin
			$display("ERROR: response still valid after the last read was delivered");
			err_flow++;
		end
		print_counts();
		if (err_val + err_proto + err_flow == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin : watchdog
		#(WD_NS);
		$display("ERROR: watchdog expired after %0d ns, the bus stopped making progress", WD_NS);
		print_counts();
		$display("** FAIL **");
		$finish;
	end

endmodule : coh_bus_tb

//--- tb.f
logic/coh_bus_pkg.sv
logic/bus_arbiter.sv
logic/rsp_queue.sv
logic/mem_ctrl.sv
logic/coh_bus_top.sv
verif/tb_clkgen.sv
verif/coh_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the coherence bus testbench with Verilator and run it
# exit status 0 only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module coh_bus_tb \
	-f tb.f \
	--Mdir obj_dir -o coh_bus_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/coh_bus_tb_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1
